// File: source/gem_tx_defines.svh
`ifndef GEM_TX_DEFINES_SVH
`define GEM_TX_DEFINES_SVH

// ---------------------------------------
// Widths
// ---------------------------------------
`define GEM_PAYLOAD_W 56            // Cluster payload per frame
`define PRBS_W        48            // Test pattern register
`define LTNCY_CNT_W   8             // Latency trigger period is 2**W clocks

// ---------------------------------------
// Test pattern
// ---------------------------------------
`define PRBS_SEED     48'hFFFFFF000000

// ---------------------------------------
// Link words and K-codes
// ---------------------------------------
// Comma pair sent while the link is held in reset
`define IDLE_WORD     32'h50BC50BC
`define IDLE_ISK      4'b0101

`define K_BC0         8'h50         // Bunch crossing zero
`define K_OVF         8'hFC         // More clusters than fit in a frame

// Rotating bunch sequence markers
`define K_SEP0        8'hBC
`define K_SEP1        8'hF7
`define K_SEP2        8'hFB
`define K_SEP3        8'hFD

// Separator source, 1 follows bxn from TTC, 0 uses the local counter
`define FRAME_SEP_TTC 1

`endif

// File: source/gem_tx_pkg.sv
`default_nettype none

`include "gem_tx_defines.svh"

package gem_tx_pkg;

  // ---------------------------------------
  // Payload
  // ---------------------------------------

  // Split of one frame payload over the two link words
  typedef struct packed {
    logic [31:0] hi;                  // Second word
    logic [23:0] lo;                  // First word, above the separator
  } tx_halves_t;

  // Same 56 bits, seen flat by the sources and split by the framer
  typedef union packed {
    logic [`GEM_PAYLOAD_W-1:0] flat;
    tx_halves_t                half;
  } tx_payload_u;

  // ---------------------------------------
  // Frame control
  // ---------------------------------------
  typedef struct packed {
    logic [11:0] bxn;                 // Bunch crossing number
    logic        bc0;                 // Orbit marker
    logic        overflow;            // Cluster overflow
  } frame_ctrl_t;

  // ---------------------------------------
  // Transmit word
  // ---------------------------------------
  typedef struct packed {
    logic [31:0] data;
    logic [3:0]  isk;                 // One K flag per byte
  } tx_word_t;

endpackage

`default_nettype wire

// File: source/gem_frame_sep.sv
`timescale 1ns/100ps
`default_nettype none

`include "gem_tx_defines.svh"

// Picks the K-code that opens each frame
module gem_frame_sep (
  input  wire                     TRG_CLK80,
  input  wire                     TRG_RST,
  input  wire gem_tx_pkg::frame_ctrl_t ctrl,
  output logic [7:0]              frm_sep
);

  logic [2:0] lcl_cnt;                // Free-running, TTC independent
  logic [1:0] sep_idx;
  logic [7:0] rot_sep;                // Rotating marker before priority

  // ---------------------------------------
  // Local sequence counter
  // ---------------------------------------
  always_ff @(posedge TRG_CLK80 or posedge TRG_RST) begin
    if (TRG_RST) begin
      lcl_cnt <= 3'd0;
    end else begin
      lcl_cnt <= lcl_cnt + 3'd1;
    end
  end

  // ---------------------------------------
  // Separator select
  // ---------------------------------------
  always_comb begin
    // Local mode holds each code for two clocks
    sep_idx = (`FRAME_SEP_TTC != 0) ? ctrl.bxn[1:0] : lcl_cnt[2:1];

    case (sep_idx)
      2'd0:    rot_sep = `K_SEP0;
      2'd1:    rot_sep = `K_SEP1;
      2'd2:    rot_sep = `K_SEP2;
      default: rot_sep = `K_SEP3;
    endcase

    if (ctrl.bc0) begin
      frm_sep = `K_BC0;               // Orbit marker wins
    end else if (ctrl.overflow) begin
      frm_sep = `K_OVF;
    end else begin
      frm_sep = rot_sep;
    end
  end

  // An X on bc0 would send an unknown K-code down the fiber
  a_bc0_known: assert property (
    @(posedge TRG_CLK80) disable iff (TRG_RST)
    !$isunknown(ctrl.bc0)
  );

endmodule

`default_nettype wire

// File: source/gem_prbs_gen.sv
`timescale 1ns/100ps
`default_nettype none

`include "gem_tx_defines.svh"

// 48-bit Fibonacci test pattern, one step per frame
module gem_prbs_gen (
  input  wire                 TRG_CLK80,
  input  wire                 TRG_RST,
  input  wire                 pat_rst,
  input  wire                 step,        // Frame sampled this clock
  input  wire                 inj_err,
  output logic [`PRBS_W-1:0]  prbs,
  output logic                strt_ltncy
);

  logic [`PRBS_W-1:0] lfsr;
  logic               fb;                   // Feedback bit into bit 0
  logic               err_pend;             // Flip bit 0 of the next sample
  logic               at_seed;              // Register still holds the seed

  // Taps 48, 47, 21, 20
  assign fb   = lfsr[47] ^ lfsr[46] ^ lfsr[20] ^ lfsr[19];
  assign prbs = lfsr ^ {{(`PRBS_W-1){1'b0}}, err_pend};

  // ---------------------------------------
  // Shift register
  // ---------------------------------------
  always_ff @(posedge TRG_CLK80 or posedge TRG_RST) begin
    if (TRG_RST) begin
      lfsr    <= `PRBS_SEED;
      at_seed <= 1'b1;
    end else if (pat_rst) begin
      lfsr    <= `PRBS_SEED;                // Hold seed while pat_rst is high
      at_seed <= 1'b1;
    end else if (step) begin
      lfsr    <= {lfsr[`PRBS_W-2:0], fb};
      at_seed <= 1'b0;
    end
  end

  // ---------------------------------------
  // Error injection and latency start
  // ---------------------------------------
  always_ff @(posedge TRG_CLK80 or posedge TRG_RST) begin
    if (TRG_RST) begin
      err_pend   <= 1'b0;
      strt_ltncy <= 1'b0;
    end else begin
      if (inj_err) begin
        err_pend <= 1'b1;                   // New request beats the clear
      end else if (step) begin
        err_pend <= 1'b0;                   // Used by this sample
      end
      if (step) begin
        strt_ltncy <= at_seed;              // High for the seed frame
      end
    end
  end

  // All zeros would lock the pattern up
  a_lfsr_live: assert property (
    @(posedge TRG_CLK80) disable iff (TRG_RST)
    lfsr != '0
  );

endmodule

`default_nettype wire

// File: source/gem_tx_framer.sv
`timescale 1ns/100ps
`default_nettype none

`include "gem_tx_defines.svh"

// Two-word framing of the payload and the latency trigger
module gem_tx_framer (
  input  wire                     TRG_CLK80,
  input  wire                     TRG_RST,
  input  wire gem_tx_pkg::tx_payload_u payload,
  input  wire [7:0]               frm_sep,
  output gem_tx_pkg::tx_word_t    tx_word,
  output logic                    tx_sel,       // 0 first word, 1 second word
  output logic                    frame_start,
  output logic                    ltncy_trig
);

  logic                         rst_tx;         // Reset stretched by one clock
  logic                         ph;             // Next word is the second one
  gem_tx_pkg::tx_payload_u      hold;           // Payload of the current frame
  logic [`LTNCY_CNT_W-1:0]      trg_cnt;

  assign frame_start = !rst_tx && !ph;

  // ---------------------------------------
  // Reset latch
  // ---------------------------------------
  always_ff @(posedge TRG_CLK80 or posedge TRG_RST) begin
    if (TRG_RST) begin
      rst_tx <= 1'b1;
    end else begin
      rst_tx <= 1'b0;                         // Released on the first clean edge
    end
  end

  // ---------------------------------------
  // Word phase
  // ---------------------------------------
  always_ff @(posedge TRG_CLK80 or posedge TRG_RST) begin
    if (TRG_RST) begin
      ph     <= 1'b0;
      tx_sel <= 1'b0;
    end else if (!rst_tx) begin
      ph     <= ~ph;
      tx_sel <= ph;                           // Phase of the word just loaded
    end
  end

  // Payload is sampled on the first word only
  always_ff @(posedge TRG_CLK80) begin
    if (frame_start) begin
      hold.flat <= payload.flat;
    end
  end

  // ---------------------------------------
  // Output word
  // ---------------------------------------
  always_ff @(posedge TRG_CLK80 or posedge TRG_RST) begin
    if (TRG_RST) begin
      tx_word <= '{data: `IDLE_WORD, isk: `IDLE_ISK};
    end else if (rst_tx) begin
      tx_word <= '{data: `IDLE_WORD, isk: `IDLE_ISK};   // Latch clock
    end else if (frame_start) begin
      tx_word <= '{data: {payload.half.lo, frm_sep}, isk: 4'b0001};
    end else begin
      tx_word <= '{data: hold.half.hi, isk: 4'b0000};
    end
  end

  // ---------------------------------------
  // Latency trigger
  // ---------------------------------------
  always_ff @(posedge TRG_CLK80 or posedge TRG_RST) begin
    if (TRG_RST) begin
      trg_cnt    <= '0;
      ltncy_trig <= 1'b0;
    end else begin
      trg_cnt    <= rst_tx ? '0 : trg_cnt + 1'b1;
      ltncy_trig <= !rst_tx && (trg_cnt == '0);  // Once per counter wrap
    end
  end

  // Once framing runs the word select never stalls
  a_sel_toggle: assert property (
    @(posedge TRG_CLK80) disable iff (TRG_RST)
    !$past(rst_tx, 2) |-> (tx_sel != $past(tx_sel))
  );

  // First word always carries the separator K flag
  a_first_isk: assert property (
    @(posedge TRG_CLK80) disable iff (TRG_RST)
    (!tx_sel && !$past(rst_tx)) |-> (tx_word.isk == 4'b0001)
  );

endmodule

`default_nettype wire

// File: source/gem_fiber_out.sv
`timescale 1ns/100ps
`default_nettype none

`include "gem_tx_defines.svh"

// GEM trigger link, framing and test pattern side
module gem_fiber_out (
  input  wire                        TRG_CLK80,
  input  wire                        TRG_RST,
  input  wire [`GEM_PAYLOAD_W-1:0]   gem_data,
  input  wire                        gem_overflow,
  input  wire [11:0]                 bxn_counter,
  input  wire                        bc0,
  input  wire                        ena_test_pat,  // High sends the test pattern
  input  wire                        pat_rst,
  input  wire                        inj_err,
  output gem_tx_pkg::tx_word_t       tx_word,
  output logic                       tx_sel,
  output logic                       strt_ltncy,
  output logic                       ltncy_trig
);

  gem_tx_pkg::frame_ctrl_t  frame_ctrl;
  gem_tx_pkg::tx_payload_u  payload;
  logic [7:0]               frm_sep;
  logic [`PRBS_W-1:0]       prbs;
  logic                     frame_start;

  assign frame_ctrl = '{bxn: bxn_counter, bc0: bc0, overflow: gem_overflow};

  // ---------------------------------------
  // Payload select
  // ---------------------------------------
  always_comb begin
    // Pattern padded with its own low byte to the full payload
    payload.flat = ena_test_pat ? {prbs, prbs[7:0]} : gem_data;
  end

  gem_frame_sep i_frame_sep (
    .TRG_CLK80 (TRG_CLK80),
    .TRG_RST   (TRG_RST),
    .ctrl      (frame_ctrl),
    .frm_sep   (frm_sep)
  );

  gem_prbs_gen i_prbs_gen (
    .TRG_CLK80  (TRG_CLK80),
    .TRG_RST    (TRG_RST),
    .pat_rst    (pat_rst),
    .step       (frame_start),                  // One step per frame
    .inj_err    (inj_err),
    .prbs       (prbs),
    .strt_ltncy (strt_ltncy)
  );

  gem_tx_framer i_tx_framer (
    .TRG_CLK80   (TRG_CLK80),
    .TRG_RST     (TRG_RST),
    .payload     (payload),
    .frm_sep     (frm_sep),
    .tx_word     (tx_word),
    .tx_sel      (tx_sel),
    .frame_start (frame_start),
    .ltncy_trig  (ltncy_trig)
  );

endmodule

`default_nettype wire

// File: dv/tb_gem_fiber_out.sv
`timescale 1ns/100ps
`default_nettype none

`include "gem_tx_defines.svh"

module tb_gem_fiber_out;

  logic                       TRG_CLK80;
  logic                       TRG_RST;
  logic [`GEM_PAYLOAD_W-1:0]  gem_data;
  logic                       gem_overflow;
  logic [11:0]                bxn_counter;
  logic                       bc0;
  logic                       ena_test_pat;
  logic                       pat_rst;
  logic                       inj_err;
  gem_tx_pkg::tx_word_t       tx_word;
  logic                       tx_sel;
  logic                       strt_ltncy;
  logic                       ltncy_trig;

  int                         errors;
  int                         checks;
  int                         tests;
  int                         tests_failed;
  logic [`PRBS_W-1:0]         model_lfsr;   // Reference pattern register
  logic                       model_seed;   // Next frame samples the seed
  logic                       model_err;    // Error pending for next frame

  gem_fiber_out i_dut (
    .TRG_CLK80    (TRG_CLK80),
    .TRG_RST      (TRG_RST),
    .gem_data     (gem_data),
    .gem_overflow (gem_overflow),
    .bxn_counter  (bxn_counter),
    .bc0          (bc0),
    .ena_test_pat (ena_test_pat),
    .pat_rst      (pat_rst),
    .inj_err      (inj_err),
    .tx_word      (tx_word),
    .tx_sel       (tx_sel),
    .strt_ltncy   (strt_ltncy),
    .ltncy_trig   (ltncy_trig)
  );

  initial begin
    TRG_CLK80 = 1'b0;
    forever #2 TRG_CLK80 = ~TRG_CLK80;      // 4 ns period
  end

  // ---------------------------------------
  // Clocking and waits
  // ---------------------------------------
  // Drive and sample point, settled after the edge
  task automatic step_clk();
    @(posedge TRG_CLK80);
    #0.5;
  endtask

  task automatic abort_on_timeout(input string what);
    $display("Timeout while waiting for %s", what);
    $display("SOME TESTS FAILED");
    $finish;
  endtask

  task automatic wait_for_sel(input logic level);
    int n;
    n = 0;
    while (tx_sel !== level) begin
      step_clk();
      n++;
      if (n > 8) abort_on_timeout("tx_sel");
    end
  endtask

  // ---------------------------------------
  // Compare tasks
  // ---------------------------------------
  task automatic compare_word(input string name, input gem_tx_pkg::tx_word_t exp,
                              input gem_tx_pkg::tx_word_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[FAIL] %s expected %h isk %b actual %h isk %b",
               name, exp.data, exp.isk, act.data, act.isk);
    end
  endtask

  task automatic compare_pulse(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[FAIL] %s expected %b actual %b", name, exp, act);
    end
  endtask

  task automatic compare_gap(input string name, input int exp, input int act);
    checks++;
    if (act != exp) begin
      errors++;
      $display("[FAIL] %s expected %0d actual %0d", name, exp, act);
    end
  endtask

  task automatic report_test(input string name, input int err0);
    tests++;
    if (errors == err0) begin
      $display("test %-16s pass", name);
    end else begin
      tests_failed++;
      $display("test %-16s fail, %0d errors", name, errors - err0);
    end
  endtask

  // ---------------------------------------
  // Reference rules
  // ---------------------------------------
  function automatic logic [7:0] expected_sep(input logic [11:0] bxn, input logic b0,
                                              input logic ovf);
    if (b0) return `K_BC0;                  // Orbit marker first
    if (ovf) return `K_OVF;
    case (bxn[1:0])
      2'd0:    return `K_SEP0;
      2'd1:    return `K_SEP1;
      2'd2:    return `K_SEP2;
      default: return `K_SEP3;
    endcase
  endfunction

  // Fibonacci step, taps 48 47 21 20, new bit at bit 0
  function automatic logic [`PRBS_W-1:0] next_pattern(input logic [`PRBS_W-1:0] p);
    logic fb;
    fb = p[47] ^ p[46] ^ p[20] ^ p[19];
    return {p[`PRBS_W-2:0], fb};
  endfunction

  task automatic check_idle(input string name);
    gem_tx_pkg::tx_word_t idle;
    idle.data = `IDLE_WORD;
    idle.isk  = `IDLE_ISK;
    compare_word({name, "/word"}, idle, tx_word);
    compare_pulse({name, "/tx_sel"}, 1'b0, tx_sel);
    compare_pulse({name, "/ltncy_trig"}, 1'b0, ltncy_trig);
    compare_pulse({name, "/strt_ltncy"}, 1'b0, strt_ltncy);
  endtask

  // ---------------------------------------
  // One frame from the pattern file
  // ---------------------------------------
  // mode bit 0 selects the test pattern, bit 1 restarts it first
  task automatic apply_frame(input string name, input int mode, input logic [55:0] data,
                             input logic [11:0] bxn, input logic b0, input logic ovf,
                             input logic inj, input logic [31:0] f1, input logic [31:0] f2);
    logic [`PRBS_W-1:0]   p;
    logic [55:0]          pl;
    logic [7:0]           sep;
    logic                 exp_strt;
    logic                 flip;
    gem_tx_pkg::tx_word_t exp1;
    gem_tx_pkg::tx_word_t exp2;
    gem_tx_pkg::tx_word_t diff;
    gem_tx_pkg::tx_word_t exp_diff;
    int                   err0;
    err0 = errors;
    if (mode[1]) begin
      wait_for_sel(1'b0);                   // Second word is next
      pat_rst = 1'b1;
      step_clk();
      pat_rst = 1'b0;
      model_lfsr = `PRBS_SEED;
      model_seed = 1'b1;
    end
    wait_for_sel(1'b1);                     // Next edge opens a frame
    ena_test_pat = mode[0];
    gem_data     = data;
    bxn_counter  = bxn;
    bc0          = b0;
    gem_overflow = ovf;
    flip      = model_err;
    p         = model_lfsr ^ {{(`PRBS_W-1){1'b0}}, flip};
    pl        = mode[0] ? {p, p[7:0]} : data;
    sep       = expected_sep(bxn, b0, ovf);
    exp1.data = {pl[23:0], sep};
    exp1.isk  = 4'b0001;
    exp2.data = pl[55:24];
    exp2.isk  = 4'b0000;
    exp_strt  = model_seed;
    // Generator steps on every frame, data mode too
    model_lfsr = next_pattern(model_lfsr);
    model_seed = 1'b0;
    model_err  = 1'b0;
    if (exp1.data !== f1 || exp2.data !== f2) begin
      errors++;
      $display("Pattern file row %s does not match the framing rules", name);
    end
    step_clk();
    compare_word({name, "/first"}, exp1, tx_word);
    compare_pulse({name, "/tx_sel0"}, 1'b0, tx_sel);
    if (mode[0]) compare_pulse({name, "/strt_ltncy"}, exp_strt, strt_ltncy);
    if (mode[0] && flip) begin
      // Pad byte repeats pattern bit 0, so it lands in word bits 8 and 16
      diff.data     = tx_word.data ^ {model_lfsr_clean(p, flip), sep};
      diff.isk      = tx_word.isk ^ 4'b0001;
      exp_diff.data = 32'h0001_0100;
      exp_diff.isk  = 4'b0000;
      compare_word({name, "/err_bits"}, exp_diff, diff);
    end
    inj_err = inj;                          // Flips the next frame
    step_clk();
    inj_err   = 1'b0;
    model_err = inj;
    compare_word({name, "/second"}, exp2, tx_word);
    compare_pulse({name, "/tx_sel1"}, 1'b1, tx_sel);
    report_test(name, err0);
  endtask

  // Low 24 payload bits of the clean pattern
  function automatic logic [23:0] model_lfsr_clean(input logic [`PRBS_W-1:0] p,
                                                   input logic flip);
    logic [`PRBS_W-1:0] c;
    c = p ^ {{(`PRBS_W-1){1'b0}}, flip};
    return {c[15:0], c[7:0]};
  endfunction

  // ---------------------------------------
  // Long pattern run from the seed
  // ---------------------------------------
  // First feedback bit enters after 23 steps from this seed
  task automatic run_pattern(input string name, input int frames);
    logic [`PRBS_W-1:0]   p;
    logic [55:0]          pl;
    logic [11:0]          bxn;
    gem_tx_pkg::tx_word_t exp1;
    gem_tx_pkg::tx_word_t exp2;
    int                   err0;
    int                   i;
    err0 = errors;
    wait_for_sel(1'b0);                     // Second word is next
    pat_rst = 1'b1;
    step_clk();
    pat_rst = 1'b0;
    p       = `PRBS_SEED;
    for (i = 0; i < frames; i++) begin
      wait_for_sel(1'b1);                   // Next edge opens a frame
      bxn          = i[11:0];
      ena_test_pat = 1'b1;
      bxn_counter  = bxn;
      bc0          = 1'b0;
      gem_overflow = 1'b0;
      pl        = {p, p[7:0]};
      exp1.data = {pl[23:0], expected_sep(bxn, 1'b0, 1'b0)};
      exp1.isk  = 4'b0001;
      exp2.data = pl[55:24];
      exp2.isk  = 4'b0000;
      step_clk();
      compare_word($sformatf("%s/%0d/first", name, i), exp1, tx_word);
      compare_pulse($sformatf("%s/%0d/strt_ltncy", name, i), i == 0, strt_ltncy);
      step_clk();
      compare_word($sformatf("%s/%0d/second", name, i), exp2, tx_word);
      p = next_pattern(p);
    end
    report_test(name, err0);
  endtask

  // ---------------------------------------
  // Main sequence
  // ---------------------------------------
  initial begin
    string       line;
    string       name;
    int          fd;
    int          code;
    int          mode;
    int          err0;
    int          n;
    int          gap;
    logic [55:0] data;
    logic [11:0] bxn;
    logic        b0;
    logic        ovf;
    logic        inj;
    logic [31:0] f1;
    logic [31:0] f2;
    errors       = 0;
    checks       = 0;
    tests        = 0;
    tests_failed = 0;
    TRG_RST      = 1'b1;
    gem_data     = '0;
    gem_overflow = 1'b0;
    bxn_counter  = '0;
    bc0          = 1'b0;
    ena_test_pat = 1'b0;
    pat_rst      = 1'b0;
    inj_err      = 1'b0;
    model_lfsr   = `PRBS_SEED;
    model_seed   = 1'b1;
    model_err    = 1'b0;

    err0 = errors;
    repeat (8) begin
      step_clk();
      check_idle("reset");
    end
    TRG_RST = 1'b0;
    step_clk();
    check_idle("latch");                    // Idle one clock past reset
    report_test("reset_idle", err0);

    fd = $fopen("dv/gem_fiber_out_patterns.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("Cannot open the pattern file");
    end else begin
      while (!$feof(fd)) begin
        code = $fgets(line, fd);
        if (code > 0 && line.len() > 1 && line[0] != "#") begin
          code = $sscanf(line, "%s %h %h %h %h %h %h %h %h",
                         name, mode, data, bxn, b0, ovf, inj, f1, f2);
          if (code == 9) begin
            apply_frame(name, mode, data, bxn, b0, ovf, inj, f1, f2);
          end else begin
            errors++;
            $display("Malformed pattern line: %s", line);
          end
        end
      end
      $fclose(fd);
    end

    run_pattern("pat_feedback", 40);        // Reaches the feedback taps

    // Latency trigger period
    err0 = errors;
    n = 0;
    while (ltncy_trig !== 1'b1) begin
      step_clk();
      n++;
      if (n > 300) abort_on_timeout("the first ltncy_trig pulse");
    end
    gap = 0;
    do begin
      step_clk();
      gap++;
      if (gap > 300) abort_on_timeout("the next ltncy_trig pulse");
    end while (ltncy_trig !== 1'b1);
    compare_gap("ltncy_trig/gap", 256, gap);
    report_test("ltncy_period", err0);

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: dv/gem_fiber_out_patterns.txt
# name mode gem_data bxn bc0 ovf inj_err first_word second_word, all hex
# mode bit0 test pattern, bit1 pat_rst first; inj_err pulse flips the next frame
data_bx0      0 123456789ABCDE 000 0 0 0 9ABCDEBC 12345678
data_bx1      0 00112233445566 001 0 0 0 445566F7 00112233
data_bx2      0 FEDCBA98765432 002 0 0 0 765432FB FEDCBA98
data_bx3      0 0F1E2D3C4B5A69 0C7 0 0 0 4B5A69FD 0F1E2D3C
bc0_over_ovf  0 A5A5A5A5A5A5A5 DEC 1 1 0 A5A5A550 A5A5A5A5
ovf_over_bxn  0 5A5A5A5A5A5A5A 001 0 1 0 5A5A5AFC 5A5A5A5A
bc0_only      0 00000000000001 003 1 0 0 00000150 00000000
# Pattern frames run back to back from the seed
pat_seed      3 00000000000000 000 0 0 0 000000BC FFFFFF00
pat_step1     1 00000000000000 001 0 0 1 000000F7 FFFFFE00
pat_step2_err 1 00000000000000 002 0 0 0 000101FB FFFFFC00
pat_step3     1 00000000000000 003 0 0 0 000000FD FFFFF800
pat_bc0       1 00000000000000 000 1 0 0 00000050 FFFFF000
pat_restart   3 00000000000000 002 0 0 0 000000FB FFFFFF00
pat_after_rst 1 00000000000000 000 0 1 0 000000FC FFFFFE00
data_back     0 13579BDF2468AC 000 0 0 0 2468ACBC 13579BDF

// File: all.f
+incdir+source
source/gem_tx_pkg.sv
source/gem_frame_sep.sv
source/gem_prbs_gen.sv
source/gem_tx_framer.sv
source/gem_fiber_out.sv
dv/tb_gem_fiber_out.sv

// File: Bender.yml
package:
  name: gem_fiber_out

sources:
  - include_dirs:
      - source
    files:
      - source/gem_tx_pkg.sv
      - source/gem_frame_sep.sv
      - source/gem_prbs_gen.sv
      - source/gem_tx_framer.sv
      - source/gem_fiber_out.sv
  - target: test
    include_dirs:
      - source
    files:
      - dv/tb_gem_fiber_out.sv
